/* Makefile */
OBJ_DIR := obj_dir
SIM_LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module vls_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module vls_tb \
		-Mdir $(OBJ_DIR) -o vls_sim
	./$(OBJ_DIR)/vls_sim | tee $(SIM_LOG)
	grep -q "ALL TESTS PASSED" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

/* dv/vls_tb.sv */
// Random-stimulus testbench for the vector load/store sequencer with request model and watchdog

`timescale 1ns/1ps

`include "vls_defs.svh"

module vls_tb;

   localparam int NUM_INSTR      = 200;
   localparam int TIMEOUT_CYCLES = NUM_INSTR * (16 * 4 + 10);

   typedef struct packed {
      vls_mem_pkg::addr_t     addr;
      vls_mem_pkg::byten_t    byten;
      vls_mem_pkg::st_data_t  data;
      vls_isa_pkg::elem_idx_t idx;
      logic                   last;
   } req_t;

   logic                   i_clk;
   logic                   i_reset_n;
   logic                   i_start;
   vls_isa_pkg::vls_mode_e i_mode;
   vls_isa_pkg::vls_eew_e  i_eew;
   vls_isa_pkg::vl_t       i_vl;
   logic                   i_vm;
   logic                   i_store;
   vls_mem_pkg::addr_t     i_base;
   vls_isa_pkg::stride_t   i_stride;
   vls_isa_pkg::vreg_t     i_vmask;
   vls_isa_pkg::vreg_t     i_vs2;
   vls_isa_pkg::vreg_t     i_vs3;
   logic                   i_mem_rtr;
   logic                   o_busy;
   logic                   o_mem_vld;
   vls_mem_pkg::addr_t     o_mem_addr;
   vls_mem_pkg::byten_t    o_mem_byten;
   vls_mem_pkg::st_data_t  o_mem_store_data;
   logic                   o_mem_store;
   vls_isa_pkg::elem_idx_t o_mem_elem_idx;
   logic                   o_mem_last;

   req_t exp_q[$];
   logic exp_store;
   int   err_cnt;
   int   chk_cnt;
   int   acc_cnt;

   vls_top vls_top_inst (.*);

   initial i_clk = 1'b0;
   always #10 i_clk = ~i_clk;

   // Zero-extended field k of width 8<<eew
   function automatic logic [63:0] reg_field(logic [127:0] r, int eew, int k);
      int           w;
      logic [127:0] sh;
      w  = 8 << eew;
      sh = r >> (k * w);
      return sh[63:0] & ((64'd1 << w) - 64'd1);
   endfunction

   function automatic logic [127:0] replicate(logic [63:0] f, int eew);
      logic [127:0] d;
      int           w;
      int           i;
      w = 8 << eew;
      d = '0;
      for (i = 0; i < 128 / w; i++) begin
         d = d | ({64'd0, f} << (i * w));
      end
      return d;
   endfunction

   // Expected requests from the instruction currently on the inputs
   task automatic build_requests(input int n);
      req_t   r;
      longint off;
      int     k;
      int     eew;
      eew = int'(i_eew);
      for (k = 0; k < n; k++) begin
         case (i_mode)
            vls_isa_pkg::VLS_MODE_UNIT:    off = longint'(k) * (longint'(1) << eew);
            vls_isa_pkg::VLS_MODE_STRIDED: off = longint'(i_stride) * k;
            default:                       off = longint'(reg_field(i_vs2, eew, k));
         endcase
         r.addr  = i_base + vls_mem_pkg::addr_t'(off);
         r.byten = (i_vm || i_vmask[k]) ?
                   vls_mem_pkg::byten_t'((16'd1 << (1 << eew)) - 16'd1) : '0;
         r.data  = replicate(reg_field(i_vs3, eew, k), eew);
         r.idx   = vls_isa_pkg::elem_idx_t'(k);
         r.last  = (k == n - 1);
         exp_q.push_back(r);
      end
   endtask

   task automatic check_request();
      req_t e;
      e = exp_q[0];
      chk_cnt++;
      assert (o_mem_addr == e.addr) else begin
         $display("FAIL %0t: addr got %h exp %h", $time, o_mem_addr, e.addr);
         err_cnt++;
      end
      assert (o_mem_byten == e.byten) else begin
         $display("FAIL %0t: byten got %h exp %h", $time, o_mem_byten, e.byten);
         err_cnt++;
      end
      assert (o_mem_store_data == e.data) else begin
         $display("FAIL %0t: store data got %h exp %h", $time, o_mem_store_data, e.data);
         err_cnt++;
      end
      assert (o_mem_elem_idx == e.idx && o_mem_last == e.last && o_mem_store == exp_store)
      else begin
         $display("FAIL %0t: idx/last/store got %0d/%b/%b exp %0d/%b/%b", $time,
                  o_mem_elem_idx, o_mem_last, o_mem_store, e.idx, e.last, exp_store);
         err_cnt++;
      end
   endtask

   task automatic run_instr();
      int n;
      int cap;
      i_mode  = vls_isa_pkg::vls_mode_e'($urandom_range(0, 2));
      i_eew   = vls_isa_pkg::vls_eew_e'($urandom_range(0, 3));
      i_vl    = ($urandom_range(0, 7) == 0) ? '0 : vls_isa_pkg::vl_t'($urandom_range(1, 16));
      i_vm    = 1'($urandom_range(0, 1));
      i_store = 1'($urandom_range(0, 1));
      i_base  = vls_mem_pkg::addr_t'({$urandom, $urandom});
      // Half the strides small, so negative offsets stay near the base
      i_stride = ($urandom_range(0, 1) == 1) ?
                 vls_isa_pkg::stride_t'(int'($urandom_range(0, 511)) - 256) :
                 vls_isa_pkg::stride_t'($urandom);
      i_vmask = {$urandom, $urandom, $urandom, $urandom};
      i_vs2   = {$urandom, $urandom, $urandom, $urandom};
      i_vs3   = {$urandom, $urandom, $urandom, $urandom};
      i_start = 1'b1;
      cap = 16 >> int'(i_eew);
      n   = (int'(i_vl) < cap) ? int'(i_vl) : cap;
      exp_store = i_store;
      build_requests(n);
      @(negedge i_clk);
      i_start = 1'b0;
      assert (n != 0 || (!o_busy && !o_mem_vld)) else begin
         $display("Zero-length instruction raised busy or valid at %0t", $time);
         err_cnt++;
      end
      while (exp_q.size() > 0) begin
         assert (o_busy && o_mem_vld) else begin
            $display("Busy or valid low with %0d requests outstanding at %0t",
                     exp_q.size(), $time);
            err_cnt++;
         end
         check_request();
         i_mem_rtr = ($urandom_range(0, 3) != 0);
         // Strobes while busy carry other fields and must be ignored
         i_start = ($urandom_range(0, 5) == 0);
         i_mode  = vls_isa_pkg::vls_mode_e'($urandom_range(0, 2));
         i_eew   = vls_isa_pkg::vls_eew_e'($urandom_range(0, 3));
         i_vl    = vls_isa_pkg::vl_t'($urandom_range(0, 16));
         i_vm    = 1'($urandom_range(0, 1));
         i_store = 1'($urandom_range(0, 1));
         i_base  = vls_mem_pkg::addr_t'({$urandom, $urandom});
         i_stride = vls_isa_pkg::stride_t'($urandom);
         i_vmask = {$urandom, $urandom, $urandom, $urandom};
         i_vs2   = {$urandom, $urandom, $urandom, $urandom};
         i_vs3   = {$urandom, $urandom, $urandom, $urandom};
         if (i_mem_rtr) begin
            void'(exp_q.pop_front());
            acc_cnt++;
         end
         @(negedge i_clk);
      end
      i_start   = 1'b0;
      i_mem_rtr = 1'b0;
      assert (!o_busy && !o_mem_vld) else begin
         $display("Busy or valid still high after the last request at %0t", $time);
         err_cnt++;
      end
   endtask

   initial begin
      void'($urandom(32'h10669c25));
      i_reset_n = 1'b0;
      i_start   = 1'b0;
      i_mode    = vls_isa_pkg::VLS_MODE_UNIT;
      i_eew     = vls_isa_pkg::VLS_EEW_8;
      i_vl      = '0;
      i_vm      = 1'b1;
      i_store   = 1'b0;
      i_base    = '0;
      i_stride  = '0;
      i_vmask   = '0;
      i_vs2     = '0;
      i_vs3     = '0;
      i_mem_rtr = 1'b0;
      exp_store = 1'b0;
      err_cnt   = 0;
      chk_cnt   = 0;
      acc_cnt   = 0;
      repeat (4) @(negedge i_clk);
      i_reset_n = 1'b1;
      assert (!o_busy && !o_mem_vld) else begin
         $display("Busy or valid high after reset");
         err_cnt++;
      end
      for (int i = 0; i < NUM_INSTR; i++) begin
         run_instr();
         repeat ($urandom_range(0, 2)) @(negedge i_clk);
      end
      $display("Checks: %0d, accepted requests: %0d, errors: %0d", chk_cnt, acc_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

   // Worst case is every instruction at 16 elements with heavy back-pressure
   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge i_clk);
      $display("Timeout after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

/* hdl/vls_agu.sv */
// Address generation for unit-stride, strided and indexed element accesses

`timescale 1ns/1ps

`include "vls_defs.svh"

module vls_agu (
   input  logic                   i_clk,
   input  logic                   i_reset_n,
   input  logic                   i_vld,
   input  vls_isa_pkg::vls_mode_e i_mode,
   input  vls_isa_pkg::vls_eew_e  i_eew,
   input  vls_mem_pkg::addr_t     i_base,
   input  vls_isa_pkg::stride_t   i_stride,
   input  vls_isa_pkg::vreg_t     i_vs2,
   input  vls_isa_pkg::elem_idx_t i_elem_idx,
   output vls_mem_pkg::addr_t     o_addr
);

   vls_mem_pkg::addr_t stride_ext;
   vls_mem_pkg::addr_t elem_idx_ext;
   vls_mem_pkg::addr_t offset;

   // Sign-extend stride so the unsigned product wraps correctly
   assign stride_ext = {{(`VLS_ADDR_WIDTH-`VLS_STRIDE_WIDTH){i_stride[`VLS_STRIDE_WIDTH-1]}},
                        i_stride};
   assign elem_idx_ext = vls_mem_pkg::addr_t'(i_elem_idx);

   always_comb begin
      case (i_mode)
         vls_isa_pkg::VLS_MODE_UNIT: begin
            offset = elem_idx_ext << i_eew;
         end
         vls_isa_pkg::VLS_MODE_STRIDED: begin
            offset = stride_ext * elem_idx_ext;
         end
         vls_isa_pkg::VLS_MODE_INDEXED: begin
            // Index field is zero-extended, upper bits of a 64-bit index drop
            offset = vls_mem_pkg::addr_t'(vls_isa_pkg::elem_field(i_vs2, i_eew, i_elem_idx));
         end
         default: begin
            offset = '0;
         end
      endcase
   end

   assign o_addr = i_base + offset;

   // Mode is decoded upstream; the spare encoding never reaches memory
   a_mode_legal: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      i_vld |-> i_mode inside {vls_isa_pkg::VLS_MODE_UNIT, vls_isa_pkg::VLS_MODE_STRIDED,
                               vls_isa_pkg::VLS_MODE_INDEXED});

endmodule

/* hdl/vls_defs.svh */
// Width macros for the vector load/store sequencer: vector length, address, store bus, index

`ifndef VLS_DEFS_SVH
`define VLS_DEFS_SVH

// Vector register length in bits
`define VLS_VLEN 128

// Memory address width
`define VLS_ADDR_WIDTH 40

// Store data bus width
`define VLS_ST_DATA_WIDTH 128

// Byte enable covers one element of up to 64 bits
`define VLS_BYTEN_WIDTH 8

// Signed byte stride for strided accesses
`define VLS_STRIDE_WIDTH 32

// Element index, 0 to VLEN/8-1
`define VLS_ELEM_IDX_WIDTH 4

// Vector length, 0 to VLEN/8 inclusive
`define VLS_VL_WIDTH 5

`endif

/* hdl/vls_elem_data.sv */
// Store element extraction, bus replication and size byte-enable generation

`timescale 1ns/1ps

`include "vls_defs.svh"

module vls_elem_data (
   input  logic                   i_clk,
   input  logic                   i_reset_n,
   input  vls_isa_pkg::vls_eew_e  i_eew,
   input  vls_isa_pkg::vreg_t     i_vs3,
   input  vls_isa_pkg::elem_idx_t i_elem_idx,
   input  logic                   i_elem_active,
   output vls_mem_pkg::byten_t    o_byten,
   output vls_mem_pkg::st_data_t  o_store_data
);

   logic [63:0]         elem;
   vls_mem_pkg::byten_t size_byten;

   assign elem = vls_isa_pkg::elem_field(i_vs3, i_eew, i_elem_idx);

   // Same element in every lane so memory can pick any byte offset
   always_comb begin
      case (i_eew)
         vls_isa_pkg::VLS_EEW_8: begin
            size_byten   = 8'h01;
            o_store_data = {(`VLS_ST_DATA_WIDTH/8){elem[7:0]}};
         end
         vls_isa_pkg::VLS_EEW_16: begin
            size_byten   = 8'h03;
            o_store_data = {(`VLS_ST_DATA_WIDTH/16){elem[15:0]}};
         end
         vls_isa_pkg::VLS_EEW_32: begin
            size_byten   = 8'h0f;
            o_store_data = {(`VLS_ST_DATA_WIDTH/32){elem[31:0]}};
         end
         default: begin
            size_byten   = 8'hff;
            o_store_data = {(`VLS_ST_DATA_WIDTH/64){elem[63:0]}};
         end
      endcase
   end

   // Masked-off element still issues, with no bytes enabled
   assign o_byten = i_elem_active ? size_byten : '0;

   a_byten_contiguous: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      (o_byten & vls_mem_pkg::byten_t'(o_byten + 1'b1)) == '0);

endmodule

/* hdl/vls_isa_pkg.sv */
// Instruction-level types: addressing modes, element widths, register and length types

`include "vls_defs.svh"

package vls_isa_pkg;

   typedef enum logic [1:0] {
      VLS_MODE_UNIT    = 2'd0,
      VLS_MODE_STRIDED = 2'd1,
      VLS_MODE_INDEXED = 2'd2
   } vls_mode_e;

   // Encoded as log2 of the element size in bytes
   typedef enum logic [1:0] {
      VLS_EEW_8  = 2'd0,
      VLS_EEW_16 = 2'd1,
      VLS_EEW_32 = 2'd2,
      VLS_EEW_64 = 2'd3
   } vls_eew_e;

   typedef logic [`VLS_VLEN-1:0]           vreg_t;
   typedef logic [`VLS_VL_WIDTH-1:0]       vl_t;
   typedef logic [`VLS_ELEM_IDX_WIDTH-1:0] elem_idx_t;
   typedef logic signed [`VLS_STRIDE_WIDTH-1:0] stride_t;

   // Element idx of a vector register at width eew, zero-extended to 64 bits
   function automatic logic [63:0] elem_field(vreg_t vreg, vls_eew_e eew, elem_idx_t idx);
      logic [63:0] field;
      case (eew)
         VLS_EEW_8:  field = 64'(vreg[8*idx +: 8]);
         VLS_EEW_16: field = 64'(vreg[16*idx[2:0] +: 16]);
         VLS_EEW_32: field = 64'(vreg[32*idx[1:0] +: 32]);
         default:    field = vreg[64*idx[0] +: 64];
      endcase
      return field;
   endfunction

endpackage

/* hdl/vls_mem_pkg.sv */
// Memory request types: address, byte enable and store data bus

`include "vls_defs.svh"

package vls_mem_pkg;

   // Request address, wraps modulo 2^ADDR_WIDTH
   typedef logic [`VLS_ADDR_WIDTH-1:0] addr_t;

   // One bit per byte of a single element
   typedef logic [`VLS_BYTEN_WIDTH-1:0] byten_t;

   // Element data replicated across the whole bus
   typedef logic [`VLS_ST_DATA_WIDTH-1:0] st_data_t;

endpackage

/* hdl/vls_seq.sv */
// Element sequencer: instruction capture, element counter, mask bit select, last flag

`timescale 1ns/1ps

`include "vls_defs.svh"

module vls_seq (
   input  logic                   i_clk,
   input  logic                   i_reset_n,
   input  logic                   i_start,
   input  vls_isa_pkg::vls_mode_e i_mode,
   input  vls_isa_pkg::vls_eew_e  i_eew,
   input  vls_isa_pkg::vl_t       i_vl,
   input  logic                   i_vm,
   input  logic                   i_store,
   input  vls_mem_pkg::addr_t     i_base,
   input  vls_isa_pkg::stride_t   i_stride,
   input  vls_isa_pkg::vreg_t     i_vmask,
   input  vls_isa_pkg::vreg_t     i_vs2,
   input  vls_isa_pkg::vreg_t     i_vs3,
   input  logic                   i_mem_rtr,
   output logic                   o_busy,
   output logic                   o_mem_vld,
   output logic                   o_mem_last,
   output vls_isa_pkg::elem_idx_t o_elem_idx,
   output logic                   o_elem_active,
   output logic                   o_store,
   output vls_isa_pkg::vls_mode_e o_mode,
   output vls_isa_pkg::vls_eew_e  o_eew,
   output vls_mem_pkg::addr_t     o_base,
   output vls_isa_pkg::stride_t   o_stride,
   output vls_isa_pkg::vreg_t     o_vs2,
   output vls_isa_pkg::vreg_t     o_vs3
);

   typedef enum logic {
      ST_IDLE,
      ST_ISSUE
   } state_e;

   state_e                 state_q;
   vls_isa_pkg::elem_idx_t elem_idx_q;
   vls_isa_pkg::elem_idx_t last_idx_q;
   vls_isa_pkg::vl_t       elem_cap;
   vls_isa_pkg::vl_t       elem_cnt;
   logic                   start_acc;
   logic                   vm_q;
   // Only one mask bit per possible element is needed
   logic [`VLS_VLEN/8-1:0] vmask_q;

   // Register holds 16, 8, 4 or 2 elements
   assign elem_cap  = vls_isa_pkg::vl_t'(`VLS_VLEN/8) >> i_eew;
   assign elem_cnt  = (i_vl < elem_cap) ? i_vl : elem_cap;
   assign start_acc = i_start && (state_q == ST_IDLE) && (elem_cnt != '0);

   always_ff @(posedge i_clk) begin
      if (!i_reset_n) begin
         state_q    <= ST_IDLE;
         elem_idx_q <= '0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (start_acc) begin
                  state_q    <= ST_ISSUE;
                  elem_idx_q <= '0;
               end
            end
            default: begin
               // Hold the element until memory takes it
               if (i_mem_rtr) begin
                  if (o_mem_last) begin
                     state_q <= ST_IDLE;
                  end else begin
                     elem_idx_q <= elem_idx_q + 1'b1;
                  end
               end
            end
         endcase
      end
   end

   // Instruction fields stay constant for the whole instruction
   always_ff @(posedge i_clk) begin
      if (start_acc) begin
         last_idx_q <= vls_isa_pkg::elem_idx_t'(elem_cnt - 1'b1);
         vm_q       <= i_vm;
         vmask_q    <= i_vmask[`VLS_VLEN/8-1:0];
         o_store    <= i_store;
         o_mode     <= i_mode;
         o_eew      <= i_eew;
         o_base     <= i_base;
         o_stride   <= i_stride;
         o_vs2      <= i_vs2;
         o_vs3      <= i_vs3;
      end
   end

   assign o_busy        = (state_q == ST_ISSUE);
   assign o_mem_vld     = (state_q == ST_ISSUE);
   assign o_mem_last    = o_mem_vld && (elem_idx_q == last_idx_q);
   assign o_elem_idx    = elem_idx_q;
   assign o_elem_active = vm_q || vmask_q[elem_idx_q];

   // A start while busy must not restart the running instruction
   a_start_ignored_busy: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      o_busy && i_start && !i_mem_rtr |=> o_busy && $stable(elem_idx_q) && $stable(last_idx_q));

   a_idx_in_range: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      o_mem_vld |-> elem_idx_q <= last_idx_q);

endmodule

/* hdl/vls_top.sv */
// Top level of the vector load/store sequencer: sequencer, AGU and store data path

`timescale 1ns/1ps

module vls_top (
   input  logic                   i_clk,
   input  logic                   i_reset_n,
   input  logic                   i_start,
   input  vls_isa_pkg::vls_mode_e i_mode,
   input  vls_isa_pkg::vls_eew_e  i_eew,
   input  vls_isa_pkg::vl_t       i_vl,
   input  logic                   i_vm,
   input  logic                   i_store,
   input  vls_mem_pkg::addr_t     i_base,
   input  vls_isa_pkg::stride_t   i_stride,
   input  vls_isa_pkg::vreg_t     i_vmask,
   input  vls_isa_pkg::vreg_t     i_vs2,
   input  vls_isa_pkg::vreg_t     i_vs3,
   input  logic                   i_mem_rtr,
   output logic                   o_busy,
   output logic                   o_mem_vld,
   output vls_mem_pkg::addr_t     o_mem_addr,
   output vls_mem_pkg::byten_t    o_mem_byten,
   output vls_mem_pkg::st_data_t  o_mem_store_data,
   output logic                   o_mem_store,
   output vls_isa_pkg::elem_idx_t o_mem_elem_idx,
   output logic                   o_mem_last
);

   logic                   elem_active;
   vls_isa_pkg::vls_mode_e mode_q;
   vls_isa_pkg::vls_eew_e  eew_q;
   vls_mem_pkg::addr_t     base_q;
   vls_isa_pkg::stride_t   stride_q;
   vls_isa_pkg::vreg_t     vs2_q;
   vls_isa_pkg::vreg_t     vs3_q;

   vls_seq vls_seq_inst (
      .i_clk         (i_clk),
      .i_reset_n     (i_reset_n),
      .i_start       (i_start),
      .i_mode        (i_mode),
      .i_eew         (i_eew),
      .i_vl          (i_vl),
      .i_vm          (i_vm),
      .i_store       (i_store),
      .i_base        (i_base),
      .i_stride      (i_stride),
      .i_vmask       (i_vmask),
      .i_vs2         (i_vs2),
      .i_vs3         (i_vs3),
      .i_mem_rtr     (i_mem_rtr),
      .o_busy        (o_busy),
      .o_mem_vld     (o_mem_vld),
      .o_mem_last    (o_mem_last),
      .o_elem_idx    (o_mem_elem_idx),
      .o_elem_active (elem_active),
      .o_store       (o_mem_store),
      .o_mode        (mode_q),
      .o_eew         (eew_q),
      .o_base        (base_q),
      .o_stride      (stride_q),
      .o_vs2         (vs2_q),
      .o_vs3         (vs3_q)
   );

   vls_agu vls_agu_inst (
      .i_clk      (i_clk),
      .i_reset_n  (i_reset_n),
      .i_vld      (o_mem_vld),
      .i_mode     (mode_q),
      .i_eew      (eew_q),
      .i_base     (base_q),
      .i_stride   (stride_q),
      .i_vs2      (vs2_q),
      .i_elem_idx (o_mem_elem_idx),
      .o_addr     (o_mem_addr)
   );

   vls_elem_data vls_elem_data_inst (
      .i_clk         (i_clk),
      .i_reset_n     (i_reset_n),
      .i_eew         (eew_q),
      .i_vs3         (vs3_q),
      .i_elem_idx    (o_mem_elem_idx),
      .i_elem_active (elem_active),
      .o_byten       (o_mem_byten),
      .o_store_data  (o_mem_store_data)
   );

endmodule

/* vlog.f */
+incdir+hdl
hdl/vls_isa_pkg.sv
hdl/vls_mem_pkg.sv
hdl/vls_seq.sv
hdl/vls_agu.sv
hdl/vls_elem_data.sv
hdl/vls_top.sv
dv/vls_tb.sv
